// File: Makefile
# Verilator simulation of the CCDU testbench

VERILATOR ?= verilator
TOP       ?= tb_gclk_ccdu
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f src.f --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: gclk_ccdu_pkg.sv
// ========================================
// CCDU shared counts, widths, DOP matrices
// sync period, vector typedefs and the div1 lookup
// ========================================
`default_nettype none

package gclk_ccdu_pkg;

  // ========================================
  // partition clock counts and field widths
  // ========================================
  localparam int NUM_OF_GRID_PRI_CLKS     = 3;  // primary grid domains
  localparam int NUM_OF_GRID_SCC_CLKS     = 6;  // gated secondary clocks
  localparam int NUM_OF_GRID_NONSCAN_CLKS = 2;  // free running non-scan clocks
  localparam int GRID_PRICLK_BITS         = 4;  // primary index field
  localparam int GRID_DIVISOR_BITS        = 4;  // divisor field

  // entry [i] belongs to DOP i
  localparam logic [NUM_OF_GRID_SCC_CLKS-1:0][GRID_PRICLK_BITS-1:0] GRID_SCC_PRICLK_MATRIX =
    {4'd2, 4'd1, 4'd1, 4'd0, 4'd0, 4'd0};
  localparam logic [NUM_OF_GRID_SCC_CLKS-1:0][GRID_DIVISOR_BITS-1:0] GRID_SCC_DIVISOR_MATRIX =
    {4'd1, 4'd2, 4'd1, 4'd4, 4'd2, 4'd1};

  // non-scan clock 0 is grid 0 / 4, clock 1 is grid 1 / 1
  localparam logic [NUM_OF_GRID_NONSCAN_CLKS-1:0][GRID_PRICLK_BITS-1:0]
    GRID_NONSCAN_PRICLK_MATRIX = {4'd1, 4'd0};
  localparam logic [NUM_OF_GRID_NONSCAN_CLKS-1:0][GRID_DIVISOR_BITS-1:0]
    GRID_NONSCAN_DIVISOR_MATRIX = {4'd1, 4'd4};

  localparam int SYNC_PERIOD = 4;  // lcm of all divisors, same in every domain

  // ========================================
  // vector types
  // ========================================
  typedef logic [NUM_OF_GRID_PRI_CLKS-1:0]     pri_vec_t;   // one bit per grid domain
  typedef logic [NUM_OF_GRID_SCC_CLKS-1:0]     scc_vec_t;   // one bit per gated DOP
  typedef logic [NUM_OF_GRID_NONSCAN_CLKS-1:0] ns_vec_t;    // one bit per non-scan clock
  typedef logic [GRID_DIVISOR_BITS-1:0]        div_cnt_t;   // DOP divider count
  typedef logic [3:0]                          sync_cnt_t;  // sync period count

  // lowest numbered divide-by-1 DOP fed by domain pri, -1 when there is none
  function automatic int first_div1_dop(input int pri);
    int pos;
    pos = -1;
    for (int i = NUM_OF_GRID_SCC_CLKS - 1; i >= 0; i--) begin
      if ((int'(GRID_SCC_PRICLK_MATRIX[i]) == pri) &&
          (int'(GRID_SCC_DIVISOR_MATRIX[i]) == 1))
      begin
        pos = i;  // walking down leaves the first match
      end
    end
    return pos;
  endfunction

endpackage

`default_nettype wire

// File: gclk_ccdu_top.sv
// ========================================
// CCDU top, sync generators and DOP wrapper
// ========================================
`timescale 1ns/100ps
`default_nettype none

module gclk_ccdu_top
  import gclk_ccdu_pkg::*;
(
  input  pri_vec_t fdop_preclk_grid,      // primary grid clocks
  input  logic     rst_n,                 // partition reset
  input  logic     fscan_mode,            // scan mode
  input  scc_vec_t fdop_scan_clk,         // scan clock per DOP
  input  scc_vec_t fscan_dop_clken,       // enable per DOP
  output scc_vec_t adop_postclk,          // gated / scan clocks
  output scc_vec_t adop_postclk_free,     // free running copies
  output ns_vec_t  adop_postclk_nonscan   // non-scan clocks
);

  pri_vec_t dom_rst_n_vec;      // reset per domain
  pri_vec_t div_sync_vec;       // gated sync per domain
  pri_vec_t div_sync_free_vec;  // free sync per domain

  // one sync generator on each grid
  for (genvar p = 0; p < NUM_OF_GRID_PRI_CLKS; p++)
  begin : g_sync
    gclk_div_sync_gen u_sync_gen (
      .preclk        (fdop_preclk_grid[p]),
      .rst_n         (rst_n),
      .fscan_mode    (fscan_mode),
      .dom_rst_n     (dom_rst_n_vec[p]),
      .div_sync      (div_sync_vec[p]),
      .div_sync_free (div_sync_free_vec[p])
    );
  end

  gclk_pccdu_dop_wrapper u_dop_wrapper (
    .fdop_preclk_grid          (fdop_preclk_grid),
    .dom_rst_n_vec             (dom_rst_n_vec),
    .fdop_preclk_div_sync      (div_sync_vec),
    .fdop_preclk_div_sync_free (div_sync_free_vec),
    .fscan_mode                (fscan_mode),
    .fdop_scan_clk             (fdop_scan_clk),
    .fscan_dop_clken           (fscan_dop_clken),
    .adop_postclk              (adop_postclk),
    .adop_postclk_free         (adop_postclk_free),
    .adop_postclk_nonscan      (adop_postclk_nonscan)
  );

endmodule

`default_nettype wire

// File: gclk_div_sync_gen.sv
// ========================================
// per domain reset synchronizer and periodic
// divider sync, gated and free variants
// ========================================
`timescale 1ns/100ps
`default_nettype none

module gclk_div_sync_gen
  import gclk_ccdu_pkg::*;
(
  input  logic preclk,         // primary grid clock of this domain
  input  logic rst_n,          // partition reset, any timing
  input  logic fscan_mode,     // scan mode masks the gated sync
  output logic dom_rst_n,      // reset after two domain edges
  output logic div_sync,       // sync for scannable DOPs
  output logic div_sync_free   // sync for non-scan dividers
);

  logic      rst_meta_q;  // first sampling stage
  logic      rst_sync_q;  // second stage, drives dom_rst_n
  sync_cnt_t sync_cnt_q;  // cycles since last sync
  logic      sync_free_q;

  // two stage reset sampling
  always_ff @(posedge preclk)
  begin
    rst_meta_q <= rst_n;
    rst_sync_q <= rst_meta_q;
  end

  assign dom_rst_n = rst_sync_q;

  // pulse on count 0, so the first one follows the first edge out of reset
  always_ff @(posedge preclk)
  begin
    if (!rst_sync_q)
    begin
      sync_cnt_q  <= '0;
      sync_free_q <= 1'b0;
    end
    else
    begin
      sync_free_q <= (sync_cnt_q == '0);
      if (sync_cnt_q == sync_cnt_t'(SYNC_PERIOD - 1))
      begin
        sync_cnt_q <= '0;
      end
      else
      begin
        sync_cnt_q <= sync_cnt_q + sync_cnt_t'(1);
      end
    end
  end

  assign div_sync_free = sync_free_q;
  assign div_sync      = sync_free_q & ~fscan_mode;  // scan freezes gated dividers

  // ========================================
  // checks
  // ========================================
  // free sync repeats exactly every SYNC_PERIOD primary cycles
  a_sync_period: assert property (@(posedge preclk) disable iff (!rst_sync_q)
    div_sync_free |=> (!div_sync_free) [* SYNC_PERIOD - 1] ##1 div_sync_free)
    else $error("gclk_div_sync_gen sync period broken");

  a_no_sync_in_scan: assert property (@(posedge preclk) fscan_mode |-> !div_sync)
    else $error("gclk_div_sync_gen gated sync during scan");

endmodule

`default_nettype wire

// File: gclk_dop.sv
// ========================================
// single DOP with synced divider, falling edge
// enable flop, clock gate and scan clock mux
// ========================================
`timescale 1ns/100ps
`default_nettype none

module gclk_dop
  import gclk_ccdu_pkg::*;
#(
  parameter int GRID_CLK_DIVISOR = 1  // primary edges per output period
)
(
  gclk_dop_if.dop bus
);

  logic fclk;        // ungated functional clock
  logic clken_q;     // enable captured on falling edge
  logic fclk_gated;  // functional clock after the gate

  // divisor must be nonzero and fit the counter
  if ((GRID_CLK_DIVISOR < 1) || (GRID_CLK_DIVISOR > (2 ** GRID_DIVISOR_BITS) - 1))
  begin : g_bad_divisor
    $error("gclk_dop divisor %0d out of range", GRID_CLK_DIVISOR);
  end

  // ========================================
  // functional clock
  // ========================================
  if (GRID_CLK_DIVISOR > 1)
  begin : g_div
    div_cnt_t cnt_q;      // position inside the output period
    div_cnt_t cnt_nxt;
    logic     div_run_q;  // first sync seen since domain reset
    logic     div_clk_q;  // registered divided clock

    always_comb
    begin
      if (bus.div_sync)
      begin
        cnt_nxt = '0;  // realign with the rest of the domain
      end
      else if (cnt_q == div_cnt_t'(GRID_CLK_DIVISOR - 1))
      begin
        cnt_nxt = '0;  // wrap
      end
      else
      begin
        cnt_nxt = cnt_q + div_cnt_t'(1);
      end
    end

    always_ff @(posedge bus.preclk)
    begin
      if (!bus.dom_rst_n)
      begin
        cnt_q     <= '0;
        div_run_q <= 1'b0;
        div_clk_q <= 1'b0;
      end
      else
      begin
        cnt_q     <= cnt_nxt;
        div_run_q <= div_run_q | bus.div_sync;  // sticky
        // high for the lower half of the count, held low until first sync
        div_clk_q <= (div_run_q | bus.div_sync) &
                     (cnt_nxt < div_cnt_t'(GRID_CLK_DIVISOR / 2));
      end
    end

    assign fclk = div_clk_q;

    // sync from the domain generator lands every divider on count 0
    a_sync_realigns: assert property (@(posedge bus.preclk) disable iff (!bus.dom_rst_n)
      bus.div_sync |=> (cnt_q == '0))
      else $error("gclk_dop div%0d count not 0 after sync", GRID_CLK_DIVISOR);
  end
  else
  begin : g_nodiv
    assign fclk = bus.preclk;  // pass the grid straight through

    // wrapper must tie sync low on undivided DOPs
    a_no_sync_div1: assert property (@(posedge bus.preclk) !bus.div_sync)
      else $error("gclk_dop div1 got a divider sync");
  end

  // ========================================
  // enable capture, gate, scan mux
  // ========================================
  // falling edge capture keeps the gate stable through the high phase of preclk
  always_ff @(negedge bus.preclk)
  begin
    if (!bus.dom_rst_n)
    begin
      clken_q <= 1'b0;
    end
    else
    begin
      clken_q <= bus.clken;
    end
  end

  assign fclk_gated       = fclk & clken_q;                              // AND gate
  assign bus.postclk      = bus.scan_mode ? bus.scan_clk : fclk_gated;   // scan wins
  assign bus.postclk_free = fclk;                                        // no gate, no scan

endmodule

`default_nettype wire

// File: gclk_dop_if.sv
// ========================================
// one DOP bundle, src and dop modports
// ========================================
`timescale 1ns/100ps
`default_nettype none

interface gclk_dop_if;

  logic preclk;        // selected primary grid clock
  logic dom_rst_n;     // domain reset, already synchronized
  logic scan_clk;      // per DOP scan clock
  logic clken;         // functional clock enable
  logic scan_mode;     // scan clock takes over postclk
  logic div_sync;      // divider sync pulse, low for div1
  logic postclk;       // gated / scan output
  logic postclk_free;  // free running divided clock

  // wrapper side
  modport src (
    output preclk,
    output dom_rst_n,
    output scan_clk,
    output clken,
    output scan_mode,
    output div_sync,
    input  postclk,
    input  postclk_free
  );

  // DOP side
  modport dop (
    input  preclk,
    input  dom_rst_n,
    input  scan_clk,
    input  clken,
    input  scan_mode,
    input  div_sync,
    output postclk,
    output postclk_free
  );

endinterface

`default_nettype wire

// File: gclk_pccdu_dop_wrapper.sv
// ========================================
// matrix driven DOP instances, gated and
// non-scan, plus div1 non-scan reuse
// ========================================
`timescale 1ns/100ps
`default_nettype none

module gclk_pccdu_dop_wrapper
  import gclk_ccdu_pkg::*;
(
  input  pri_vec_t fdop_preclk_grid,           // primary grid clocks
  input  pri_vec_t dom_rst_n_vec,              // synchronized reset per domain
  input  pri_vec_t fdop_preclk_div_sync,       // gated sync per domain
  input  pri_vec_t fdop_preclk_div_sync_free,  // sync that survives scan
  input  logic     fscan_mode,
  input  scc_vec_t fdop_scan_clk,              // scan clock per DOP
  input  scc_vec_t fscan_dop_clken,            // enable per DOP
  output scc_vec_t adop_postclk,               // gated / scan clocks
  output scc_vec_t adop_postclk_free,          // free running copies
  output ns_vec_t  adop_postclk_nonscan        // non-scan clocks
);

  // ========================================
  // gated DOPs
  // ========================================
  for (genvar d = 0; d < NUM_OF_GRID_SCC_CLKS; d++)
  begin : g_dop
    localparam int PRI = int'(GRID_SCC_PRICLK_MATRIX[d]);   // source domain
    localparam int DIV = int'(GRID_SCC_DIVISOR_MATRIX[d]);  // divisor

    gclk_dop_if u_dop_if ();

    if (PRI >= NUM_OF_GRID_PRI_CLKS)
    begin : g_pri_range
      $error("DOP %0d names domain %0d, only %0d exist", d, PRI, NUM_OF_GRID_PRI_CLKS);
    end

    assign u_dop_if.preclk    = fdop_preclk_grid[PRI];
    assign u_dop_if.dom_rst_n = dom_rst_n_vec[PRI];
    assign u_dop_if.scan_clk  = fdop_scan_clk[d];
    assign u_dop_if.clken     = fscan_dop_clken[d];
    assign u_dop_if.scan_mode = fscan_mode;

    if (DIV > 1)
    begin : g_sync
      assign u_dop_if.div_sync = fdop_preclk_div_sync[PRI];  // keep in step with the domain
    end
    else
    begin : g_nosync
      assign u_dop_if.div_sync = 1'b0;  // nothing to align
    end

    gclk_dop #(
      .GRID_CLK_DIVISOR (DIV)
    ) u_dop (
      .bus (u_dop_if.dop)
    );

    assign adop_postclk[d]      = u_dop_if.postclk;
    assign adop_postclk_free[d] = u_dop_if.postclk_free;
  end

  // ========================================
  // non-scan clocks
  // ========================================
  for (genvar n = 0; n < NUM_OF_GRID_NONSCAN_CLKS; n++)
  begin : g_ns
    localparam int PRI = int'(GRID_NONSCAN_PRICLK_MATRIX[n]);
    localparam int DIV = int'(GRID_NONSCAN_DIVISOR_MATRIX[n]);

    if (PRI >= NUM_OF_GRID_PRI_CLKS)
    begin : g_pri_range
      $error("non-scan clock %0d names domain %0d, only %0d exist",
             n, PRI, NUM_OF_GRID_PRI_CLKS);
    end

    if (DIV > 1)
    begin : g_ns_div
      // own divider, always enabled, never in scan
      gclk_dop_if u_ns_if ();

      assign u_ns_if.preclk    = fdop_preclk_grid[PRI];
      assign u_ns_if.dom_rst_n = dom_rst_n_vec[PRI];
      assign u_ns_if.scan_clk  = 1'b0;
      assign u_ns_if.clken     = 1'b1;
      assign u_ns_if.scan_mode = 1'b0;
      assign u_ns_if.div_sync  = fdop_preclk_div_sync_free[PRI];  // runs through scan

      gclk_dop #(
        .GRID_CLK_DIVISOR (DIV)
      ) u_ns_dop (
        .bus (u_ns_if.dop)
      );

      assign adop_postclk_nonscan[n] = u_ns_if.postclk_free;
    end
    else
    begin : g_ns_nodiv
      // borrow the free output of a div1 DOP on the same grid
      localparam int DIV1_POS = first_div1_dop(PRI);

      if (DIV1_POS < 0)
      begin : g_no_div1
        $error("non-scan clock %0d has no div1 DOP in domain %0d", n, PRI);
      end

      assign adop_postclk_nonscan[n] = adop_postclk_free[DIV1_POS];
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
gclk_ccdu_pkg.sv
gclk_dop_if.sv
gclk_dop.sv
gclk_div_sync_gen.sv
gclk_pccdu_dop_wrapper.sv
gclk_ccdu_top.sv
tb_gclk_ccdu.sv

// File: tb_gclk_ccdu_checks.svh
// ========================================
// typed compare tasks and error counters
// ========================================
`ifndef TB_GCLK_CCDU_CHECKS_SVH
`define TB_GCLK_CCDU_CHECKS_SVH

int err_cnt     = 0;  // value mismatches
int timeout_cnt = 0;  // waits that ran out

// rising edge count over a window
task automatic check_count(input string name, input int exp, input int act);
  if (exp !== act)
  begin
    err_cnt++;
    $display("FAIL %s expected %0d actual %0d", name, exp, act);
  end
endtask

// one bit per gated DOP
task automatic check_scc(input string name, input scc_vec_t exp, input scc_vec_t act);
  if (exp !== act)
  begin
    err_cnt++;
    $display("FAIL %s expected %b actual %b", name, exp, act);
  end
endtask

// one bit per non-scan clock
task automatic check_ns(input string name, input ns_vec_t exp, input ns_vec_t act);
  if (exp !== act)
  begin
    err_cnt++;
    $display("FAIL %s expected %b actual %b", name, exp, act);
  end
endtask

// wait loop ran out of cycles
task automatic report_timeout(input string what);
  timeout_cnt++;
  $display("timeout: %s", what);
endtask

`endif

// File: tb_gclk_ccdu.sv
// ========================================
// CCDU testbench, grid clocks, edge counters
// and directed tests for division, gating, scan
// ========================================
`timescale 1ns/100ps
`default_nettype none

module tb_gclk_ccdu
  import gclk_ccdu_pkg::*;
();

  `include "tb_gclk_ccdu_checks.svh"

  localparam int WINDOW     = 64;     // grid 0 cycles per measurement, 16 grid 2 cycles
  localparam int WAIT_LIMIT = 200;    // grid 0 cycles before a wait gives up
  localparam int WATCHDOG   = 50000;  // ns

  logic     grid0;
  logic     grid1;
  logic     grid2;
  logic     grid2_tick;  // grid 2 toggles every second grid 0 rise
  pri_vec_t fdop_preclk_grid;
  logic     rst_n;
  logic     fscan_mode;
  scc_vec_t fdop_scan_clk;
  scc_vec_t fscan_dop_clken;
  scc_vec_t adop_postclk;
  scc_vec_t adop_postclk_free;
  ns_vec_t  adop_postclk_nonscan;

  int       seed;
  scc_vec_t divided_mask;     // DOPs with divisor above 1
  ns_vec_t  ns_divided_mask;  // non-scan clocks with divisor above 1
  int       scan_pulses [NUM_OF_GRID_SCC_CLKS];

  // free running edge counters, windows use differences
  int post_cnt  [NUM_OF_GRID_SCC_CLKS]     = '{default: 0};
  int free_cnt  [NUM_OF_GRID_SCC_CLKS]     = '{default: 0};
  int ns_cnt    [NUM_OF_GRID_NONSCAN_CLKS] = '{default: 0};
  int post_start[NUM_OF_GRID_SCC_CLKS];
  int free_start[NUM_OF_GRID_SCC_CLKS];
  int ns_start  [NUM_OF_GRID_NONSCAN_CLKS];

  assign fdop_preclk_grid = {grid2, grid1, grid0};

  gclk_ccdu_top u_dut (
    .fdop_preclk_grid     (fdop_preclk_grid),
    .rst_n                (rst_n),
    .fscan_mode           (fscan_mode),
    .fdop_scan_clk        (fdop_scan_clk),
    .fscan_dop_clken      (fscan_dop_clken),
    .adop_postclk         (adop_postclk),
    .adop_postclk_free    (adop_postclk_free),
    .adop_postclk_nonscan (adop_postclk_nonscan)
  );

  // ========================================
  // clocks and counters
  // ========================================
  // slower grids settle before grid 0 rises, so all three share the edge
  always
  begin
    #4;
    grid1 = ~grid1;
    if (grid2_tick)
    begin
      grid2 = ~grid2;
    end
    grid2_tick = ~grid2_tick;
    grid0 = 1'b1;
    #4;
    grid0 = 1'b0;
  end

  for (genvar g = 0; g < NUM_OF_GRID_SCC_CLKS; g++)
  begin : g_scc_cnt
    always @(posedge adop_postclk[g]) post_cnt[g] = post_cnt[g] + 1;
    always @(posedge adop_postclk_free[g]) free_cnt[g] = free_cnt[g] + 1;
  end

  for (genvar g = 0; g < NUM_OF_GRID_NONSCAN_CLKS; g++)
  begin : g_ns_cnt
    always @(posedge adop_postclk_nonscan[g]) ns_cnt[g] = ns_cnt[g] + 1;
  end

  // ========================================
  // expected values and helpers
  // ========================================
  // grid p runs at 1 / 2**p of grid 0
  function automatic int dom_cycles(input int pri);
    return WINDOW >> pri;
  endfunction

  function automatic int free_expect(input int i);
    return dom_cycles(int'(GRID_SCC_PRICLK_MATRIX[i])) / int'(GRID_SCC_DIVISOR_MATRIX[i]);
  endfunction

  function automatic int ns_expect(input int i);
    return dom_cycles(int'(GRID_NONSCAN_PRICLK_MATRIX[i])) /
           int'(GRID_NONSCAN_DIVISOR_MATRIX[i]);
  endfunction

  task automatic settle(input int n);
    repeat (n) @(posedge grid0);
  endtask

  task automatic take_snapshot();
    post_start = post_cnt;
    free_start = free_cnt;
    ns_start   = ns_cnt;
  endtask

  // waits for grid 2 to reach level, counted in grid 0 rises
  task automatic wait_grid2(input logic level);
    logic prev;
    int   n;
    bit   seen;
    prev = grid2;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 8)
    begin
      @(posedge grid0);
      n++;
      if (grid2 == level && prev != level)
      begin
        seen = 1'b1;
      end
      prev = grid2;
    end
    if (!seen)
    begin
      report_timeout($sformatf("grid 2 never reached level %0b", level));
    end
  endtask

  // WINDOW grid 0 cycles between two falling edges, optional scan pulses
  task automatic run_window(input bit drive_scan);
    @(negedge grid0);
    take_snapshot();
    for (int k = 0; k < WINDOW; k++)
    begin
      @(posedge grid0);
      if (drive_scan)
      begin
        for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
        begin
          fdop_scan_clk[i] <= (k < 16) && (k % 2 == 0) && (k / 2 < scan_pulses[i]);
        end
      end
      @(negedge grid0);
    end
  endtask

  // ========================================
  // directed tests
  // ========================================
  // reset spans 3 grid 2 cycles so every domain sees it twice
  task automatic test_reset();
    int n;
    wait_grid2(1'b1);
    wait_grid2(1'b1);
    wait_grid2(1'b0);
    for (int k = 0; k < 2; k++)
    begin
      @(posedge grid0);
      #1;  // inside the high phase, each div1 grid is high in one of the two samples
      check_scc("reset_gated", '0, adop_postclk);
      check_scc("reset_free", '0, adop_postclk_free & divided_mask);
      check_ns("reset_nonscan", '0, adop_postclk_nonscan & ns_divided_mask);
    end
    @(posedge grid0);
    rst_n <= 1'b1;
    take_snapshot();
    n = 0;
    while (n < WAIT_LIMIT && (free_cnt[2] == free_start[2] || free_cnt[4] == free_start[4]))
    begin
      @(negedge grid0);
      n++;
    end
    if (n >= WAIT_LIMIT)
    begin
      report_timeout("divided clocks never started after reset");
    end
    settle(8);
  endtask

  task automatic test_division(input string tag);
    run_window(1'b0);
    for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
    begin
      check_count($sformatf("%s_gated_%0d", tag, i), free_expect(i),
                  post_cnt[i] - post_start[i]);
      check_count($sformatf("%s_free_%0d", tag, i), free_expect(i),
                  free_cnt[i] - free_start[i]);
    end
    for (int i = 0; i < NUM_OF_GRID_NONSCAN_CLKS; i++)
    begin
      check_count($sformatf("%s_nonscan_%0d", tag, i), ns_expect(i),
                  ns_cnt[i] - ns_start[i]);
    end
  endtask

  // div4 rises only with div2, grid 1 div2 rises only with grid 1
  task automatic test_alignment();
    logic prev1;
    logic prev2;
    logic prev4;
    logic prev_g1;
    int   bad_div4;
    int   bad_grid1;
    int   div4_rises;
    bad_div4   = 0;
    bad_grid1  = 0;
    div4_rises = 0;
    @(negedge grid0);
    prev1   = adop_postclk_free[1];
    prev2   = adop_postclk_free[2];
    prev4   = adop_postclk_free[4];
    prev_g1 = grid1;
    for (int k = 0; k < WINDOW; k++)
    begin
      @(negedge grid0);
      if (adop_postclk_free[2] && !prev2)
      begin
        div4_rises++;
        if (!(adop_postclk_free[1] && !prev1))
        begin
          bad_div4++;
        end
      end
      if (adop_postclk_free[4] && !prev4 && !(grid1 && !prev_g1))
      begin
        bad_grid1++;
      end
      prev1   = adop_postclk_free[1];
      prev2   = adop_postclk_free[2];
      prev4   = adop_postclk_free[4];
      prev_g1 = grid1;
    end
    check_count("align_div4_rises", WINDOW / 4, div4_rises);
    check_count("align_div4_without_div2", 0, bad_div4);
    check_count("align_dop4_off_grid1", 0, bad_grid1);
  endtask

  task automatic test_gating();
    scc_vec_t off;
    scc_vec_t active;
    off = scc_vec_t'($random(seed));
    if (off == '0)
    begin
      off = scc_vec_t'(1);
    end
    @(posedge grid0);
    fscan_dop_clken <= ~off;
    settle(8);
    run_window(1'b0);
    active = '0;
    for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
    begin
      active[i] = (post_cnt[i] != post_start[i]);
      check_count($sformatf("gating_gated_%0d", i), off[i] ? 0 : free_expect(i),
                  post_cnt[i] - post_start[i]);
      check_count($sformatf("gating_free_%0d", i), free_expect(i),
                  free_cnt[i] - free_start[i]);
    end
    check_scc("gating_active", ~off, active);
    @(posedge grid0);
    fscan_dop_clken <= '1;
    settle(8);
  endtask

  // enables low too, so non-scan clocks are shown to ignore both
  task automatic test_scan();
    for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
    begin
      scan_pulses[i] = 1 + int'($unsigned($random(seed)) % 8);
    end
    @(posedge grid0);
    fscan_mode      <= 1'b1;
    fscan_dop_clken <= '0;
    settle(8);
    run_window(1'b1);
    for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
    begin
      check_count($sformatf("scan_gated_%0d", i), scan_pulses[i],
                  post_cnt[i] - post_start[i]);
      check_count($sformatf("scan_free_%0d", i), free_expect(i),
                  free_cnt[i] - free_start[i]);
    end
    for (int i = 0; i < NUM_OF_GRID_NONSCAN_CLKS; i++)
    begin
      check_count($sformatf("scan_nonscan_%0d", i), ns_expect(i),
                  ns_cnt[i] - ns_start[i]);
    end
    @(posedge grid0);
    fscan_mode      <= 1'b0;
    fdop_scan_clk   <= '0;
    fscan_dop_clken <= '1;
    settle(16);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial
  begin
    grid0           = 1'b0;
    grid1           = 1'b0;
    grid2           = 1'b0;
    grid2_tick      = 1'b0;
    rst_n           = 1'b0;
    fscan_mode      = 1'b0;
    fdop_scan_clk   = '0;
    fscan_dop_clken = '1;
    seed            = 32'h5553;
    divided_mask    = '0;
    ns_divided_mask = '0;
    for (int i = 0; i < NUM_OF_GRID_SCC_CLKS; i++)
    begin
      divided_mask[i] = (int'(GRID_SCC_DIVISOR_MATRIX[i]) > 1);
    end
    for (int i = 0; i < NUM_OF_GRID_NONSCAN_CLKS; i++)
    begin
      ns_divided_mask[i] = (int'(GRID_NONSCAN_DIVISOR_MATRIX[i]) > 1);
    end

    test_reset();
    test_division("div");
    test_alignment();
    test_gating();
    test_scan();
    test_division("after_scan");  // dividers back in step after scan

    $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // hard stop if the sequence stalls
  initial
  begin
    #WATCHDOG;
    $display("simulation ran past its time limit without finishing the tests");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
